/* common/mmu_pkg.sv */
package mmu_pkg;

    // address and field widths
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [18:0] vppn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;
    typedef logic [5:0]  ps_t;
    typedef logic [2:0]  seg_t;

    // supported page sizes
    localparam ps_t PS_4K = 6'd12;
    localparam ps_t PS_4M = 6'd21;

    localparam plv_t PLV_KERNEL = 2'd0;
    localparam plv_t PLV_USER   = 2'd3;

    typedef enum logic [2:0] {
        EXC_NONE = 3'd0,
        EXC_TLBR = 3'd1,
        EXC_PIF  = 3'd2,
        EXC_PIL  = 3'd3,
        EXC_PIS  = 3'd4,
        EXC_PPI  = 3'd5,
        EXC_PME  = 3'd6
    } xlat_exc_e;

    // one half of an entry pair
    typedef struct packed {
        ppn_t ppn;
        plv_t plv;
        mat_t mat;
        logic d;
        logic v;
    } tlb_page_t;

    typedef struct packed {
        logic      e;
        vppn_t     vppn;
        ps_t       ps;
        asid_t     asid;
        logic      g;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_entry_t;

    typedef struct packed {
        logic plv0;
        logic plv3;
        seg_t vseg;
        seg_t pseg;
        mat_t mat;
    } dmw_cfg_t;

    // csr fields used by translation
    typedef struct packed {
        logic     mapped;
        plv_t     crmd_plv;
        mat_t     datm;
        asid_t    asid;
        dmw_cfg_t dmw0;
        dmw_cfg_t dmw1;
    } mmu_csr_t;

    typedef struct packed {
        logic      found;
        ps_t       ps;
        tlb_page_t page;
    } tlb_hit_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] op;
        asid_t      asid;
        vppn_t      vppn;
    } inv_req_t;

    typedef struct packed {
        logic   req;
        logic   wr;
        vaddr_t vaddr;
    } xlat_req_t;

    typedef struct packed {
        logic      valid;
        xlat_exc_e exc;
        paddr_t    paddr;
        mat_t      mat;
    } xlat_resp_t;

endpackage

/* tlb/tlb_array.sv */
`timescale 1ns/1ps

module tlb_array #(
    parameter int TLB_NUM = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         we,
    input  logic [$clog2(TLB_NUM)-1:0]   w_index,
    input  mmu_pkg::tlb_entry_t          w_entry,
    input  mmu_pkg::inv_req_t            inv,
    output mmu_pkg::tlb_entry_t          entries [TLB_NUM]
);

    localparam int IDX_W = $clog2(TLB_NUM);

    logic [TLB_NUM-1:0] inv_sel;

    // vppn compare honoring the entry page size
    function automatic logic vppn_eq(
        input mmu_pkg::tlb_entry_t ent,
        input mmu_pkg::vppn_t      vppn
    );
        logic eq;
        if (ent.ps == mmu_pkg::PS_4M) begin
            eq = (ent.vppn[18:9] == vppn[18:9]);
        end else begin
            eq = (ent.vppn == vppn);
        end
        return eq;
    endfunction

    // invtlb selection per entry
    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            logic asid_eq;
            logic va_eq;
            asid_eq = (entries[i].asid == inv.asid);
            va_eq   = vppn_eq(entries[i], inv.vppn);
            case (inv.op)
                5'd0, 5'd1: begin
                    inv_sel[i] = 1'b1;
                end
                5'd2: begin
                    inv_sel[i] = entries[i].g;
                end
                5'd3: begin
                    inv_sel[i] = ~entries[i].g;
                end
                5'd4: begin
                    inv_sel[i] = ~entries[i].g & asid_eq;
                end
                5'd5: begin
                    inv_sel[i] = ~entries[i].g & asid_eq & va_eq;
                end
                5'd6: begin
                    inv_sel[i] = (entries[i].g | asid_eq) & va_eq;
                end
                default: begin
                    inv_sel[i] = 1'b0;
                end
            endcase
        end
    end

    // reset clears every e bit
    always_ff @(posedge clk) begin
        for (int i = 0; i < TLB_NUM; i++) begin
            if (!rst_n) begin
                entries[i].e <= 1'b0;
            end else if (we && w_index == IDX_W'(i)) begin
                entries[i] <= w_entry;
            end else if (inv.valid && inv_sel[i]) begin
                entries[i].e <= 1'b0;
            end
        end
    end

    // write and invtlb never arrive in the same cycle
    a_no_we_inv: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(we && inv.valid)
    );

    a_index_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        we |-> (int'(w_index) < TLB_NUM)
    );

endmodule

/* tlb/tlb_match.sv */
`timescale 1ns/1ps

module tlb_match #(
    parameter int TLB_NUM = 16
) (
    input  mmu_pkg::tlb_entry_t entries [TLB_NUM],
    input  mmu_pkg::vaddr_t     vaddr,
    input  mmu_pkg::asid_t      asid,
    output mmu_pkg::tlb_hit_t   hit
);

    logic [TLB_NUM-1:0] match;

    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            logic va_eq;
            if (entries[i].ps == mmu_pkg::PS_4M) begin
                // 4M pair only compares the upper ten vppn bits
                va_eq = (entries[i].vppn[18:9] == vaddr[31:22]);
            end else begin
                va_eq = (entries[i].vppn == vaddr[31:13]);
            end
            match[i] = entries[i].e
                     & (entries[i].g | (entries[i].asid == asid))
                     & va_eq;
        end
    end

    // entries never overlap, so at most one match bit is set
    always_comb begin
        hit = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            logic odd;
            if (entries[i].ps == mmu_pkg::PS_4M) begin
                odd = vaddr[21];
            end else begin
                odd = vaddr[12];
            end
            if (match[i]) begin
                hit.found = 1'b1;
                hit.ps    = entries[i].ps;
                hit.page  = odd ? entries[i].page1 : entries[i].page0;
            end
        end
    end

endmodule

/* hdl/addr_translate.sv */
`timescale 1ns/1ps

module addr_translate #(
    parameter bit FETCH_PORT = 1'b0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mmu_pkg::mmu_csr_t    csr,
    input  mmu_pkg::xlat_req_t   req,
    input  mmu_pkg::tlb_hit_t    hit,
    output mmu_pkg::xlat_resp_t  resp
);

    logic                dmw0_hit;
    logic                dmw1_hit;
    mmu_pkg::paddr_t     tlb_paddr;
    mmu_pkg::xlat_exc_e  tlb_exc;
    mmu_pkg::paddr_t     paddr_d;
    mmu_pkg::mat_t       mat_d;
    mmu_pkg::xlat_exc_e  exc_d;

    // window enable for the current privilege level
    function automatic logic dmw_hit(
        input mmu_pkg::dmw_cfg_t dmw,
        input mmu_pkg::plv_t     plv,
        input mmu_pkg::seg_t     seg
    );
        logic plv_ok;
        plv_ok = ((plv == mmu_pkg::PLV_KERNEL) & dmw.plv0)
               | ((plv == mmu_pkg::PLV_USER) & dmw.plv3);
        return plv_ok & (dmw.vseg == seg);
    endfunction

    assign dmw0_hit = dmw_hit(csr.dmw0, csr.crmd_plv, req.vaddr[31:29]);
    assign dmw1_hit = dmw_hit(csr.dmw1, csr.crmd_plv, req.vaddr[31:29]);

    always_comb begin
        if (hit.ps == mmu_pkg::PS_4M) begin
            tlb_paddr = {hit.page.ppn[19:9], req.vaddr[20:0]};
        end else begin
            tlb_paddr = {hit.page.ppn, req.vaddr[11:0]};
        end
    end

    // first tlb exception class that applies wins
    always_comb begin
        if (!hit.found) begin
            tlb_exc = mmu_pkg::EXC_TLBR;
        end else if (!hit.page.v) begin
            if (FETCH_PORT) begin
                tlb_exc = mmu_pkg::EXC_PIF;
            end else begin
                tlb_exc = req.wr ? mmu_pkg::EXC_PIS : mmu_pkg::EXC_PIL;
            end
        end else if (csr.crmd_plv == mmu_pkg::PLV_USER
                     && hit.page.plv == mmu_pkg::PLV_KERNEL) begin
            tlb_exc = mmu_pkg::EXC_PPI;
        end else if (!FETCH_PORT && req.wr && !hit.page.d
                     && (csr.crmd_plv == mmu_pkg::PLV_KERNEL
                         || csr.crmd_plv == hit.page.plv)) begin
            tlb_exc = mmu_pkg::EXC_PME;
        end else begin
            tlb_exc = mmu_pkg::EXC_NONE;
        end
    end

    // priority order is direct, dmw0, dmw1, tlb
    always_comb begin
        if (!csr.mapped) begin
            paddr_d = req.vaddr;
            mat_d   = csr.datm;
            exc_d   = mmu_pkg::EXC_NONE;
        end else if (dmw0_hit) begin
            paddr_d = {csr.dmw0.pseg, req.vaddr[28:0]};
            mat_d   = csr.dmw0.mat;
            exc_d   = mmu_pkg::EXC_NONE;
        end else if (dmw1_hit) begin
            paddr_d = {csr.dmw1.pseg, req.vaddr[28:0]};
            mat_d   = csr.dmw1.mat;
            exc_d   = mmu_pkg::EXC_NONE;
        end else begin
            paddr_d = tlb_paddr;
            mat_d   = hit.page.mat;
            exc_d   = tlb_exc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp.valid <= 1'b0;
            resp.exc   <= mmu_pkg::EXC_NONE;
        end else begin
            resp.valid <= req.req;
            resp.exc   <= req.req ? exc_d : mmu_pkg::EXC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (req.req) begin
            resp.paddr <= paddr_d;
            resp.mat   <= mat_d;
        end
    end

    a_idle_no_exc: assert property (
        @(posedge clk) disable iff (!rst_n)
        !resp.valid |-> (resp.exc == mmu_pkg::EXC_NONE)
    );

endmodule

/* hdl/mmu_top.sv */
`timescale 1ns/1ps

module mmu_top #(
    parameter int TLB_NUM = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  mmu_pkg::mmu_csr_t           csr,
    input  logic                        tlb_we,
    input  logic [$clog2(TLB_NUM)-1:0]  w_index,
    input  mmu_pkg::tlb_entry_t         w_entry,
    input  mmu_pkg::inv_req_t           inv,
    input  mmu_pkg::xlat_req_t          fetch_req,
    input  mmu_pkg::xlat_req_t          data_req,
    output mmu_pkg::xlat_resp_t         fetch_resp,
    output mmu_pkg::xlat_resp_t         data_resp
);

    mmu_pkg::tlb_entry_t entries [TLB_NUM];
    mmu_pkg::tlb_hit_t   fetch_hit;
    mmu_pkg::tlb_hit_t   data_hit;

    tlb_array #(.TLB_NUM(TLB_NUM)) u_tlb_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (tlb_we),
        .w_index (w_index),
        .w_entry (w_entry),
        .inv     (inv),
        .entries (entries)
    );

    // one search port per translation path
    tlb_match #(.TLB_NUM(TLB_NUM)) u_fetch_match (
        .entries (entries),
        .vaddr   (fetch_req.vaddr),
        .asid    (csr.asid),
        .hit     (fetch_hit)
    );

    tlb_match #(.TLB_NUM(TLB_NUM)) u_data_match (
        .entries (entries),
        .vaddr   (data_req.vaddr),
        .asid    (csr.asid),
        .hit     (data_hit)
    );

    addr_translate #(.FETCH_PORT(1'b1)) u_fetch_xlat (
        .clk   (clk),
        .rst_n (rst_n),
        .csr   (csr),
        .req   (fetch_req),
        .hit   (fetch_hit),
        .resp  (fetch_resp)
    );

    addr_translate #(.FETCH_PORT(1'b0)) u_data_xlat (
        .clk   (clk),
        .rst_n (rst_n),
        .csr   (csr),
        .req   (data_req),
        .hit   (data_hit),
        .resp  (data_resp)
    );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        // release on a falling edge, away from the sampling edge
        repeat (RST_CYCLES) @(negedge clk);
        rst_n <= 1'b1;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

/* bench/mmu_tb.sv */
`timescale 1ns/1ps

module mmu_tb;

    localparam int TLB_NUM = 16;

    logic                clk;
    logic                rst_n;
    mmu_pkg::mmu_csr_t   csr;
    logic                tlb_we;
    logic [3:0]          w_index;
    mmu_pkg::tlb_entry_t w_entry;
    mmu_pkg::inv_req_t   inv;
    mmu_pkg::xlat_req_t  fetch_req;
    mmu_pkg::xlat_req_t  data_req;
    mmu_pkg::xlat_resp_t fetch_resp;
    mmu_pkg::xlat_resp_t data_resp;

    // reference model and expected responses
    mmu_pkg::tlb_entry_t model_tlb [TLB_NUM];
    mmu_pkg::xlat_resp_t exp_fetch;
    mmu_pkg::xlat_resp_t exp_data;
    logic                exp_fetch_addr;
    logic                exp_data_addr;
    logic [31:0]         lfsr = 32'hd41;
    int                  cycle_count = 0;
    int                  cycle_limit = 0;
    string               lines [$];

    tb_clock #(.PERIOD_NS(100), .RST_CYCLES(16)) u_clock (.clk(clk), .rst_n(rst_n));

    mmu_top #(.TLB_NUM(TLB_NUM)) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr        (csr),
        .tlb_we     (tlb_we),
        .w_index    (w_index),
        .w_entry    (w_entry),
        .inv        (inv),
        .fetch_req  (fetch_req),
        .data_req   (data_req),
        .fetch_resp (fetch_resp),
        .data_resp  (data_resp)
    );

    always @(posedge clk) cycle_count <= cycle_count + 1;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_valid(input string port, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("ERR %0t %s valid got %b expected %b", $time, port, got, exp));
        end
    endtask

    task automatic check_exc(input string port, input mmu_pkg::xlat_exc_e got,
                             input mmu_pkg::xlat_exc_e exp);
        if (got !== exp) begin
            fail_now($sformatf("ERR %0t %s exc got %0d expected %s", $time, port, got, exp.name()));
        end
    endtask

    task automatic check_paddr(input string port, input mmu_pkg::paddr_t got,
                               input mmu_pkg::paddr_t exp);
        if (got !== exp) begin
            fail_now($sformatf("ERR %0t %s paddr got %h expected %h", $time, port, got, exp));
        end
    endtask

    task automatic check_mat(input string port, input mmu_pkg::mat_t got, input mmu_pkg::mat_t exp);
        if (got !== exp) begin
            fail_now($sformatf("ERR %0t %s mat got %h expected %h", $time, port, got, exp));
        end
    endtask

    task automatic check_port(input string port, input mmu_pkg::xlat_resp_t got,
                              input mmu_pkg::xlat_resp_t exp, input logic addr_chk);
        check_valid(port, got.valid, exp.valid);
        if (exp.valid && exp.exc == mmu_pkg::EXC_NONE && addr_chk) begin
            check_exc(port, got.exc, exp.exc);
            check_paddr(port, got.paddr, exp.paddr);
            check_mat(port, got.mat, exp.mat);
        end else if (exp.valid) begin
            check_exc(port, got.exc, exp.exc);
        end
    endtask

    task automatic need_fields(input int got, input int want, input string line);
        if (got != want) begin
            fail_now({"malformed line in case file: ", line});
        end
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic mmu_pkg::vaddr_t random_offset(input mmu_pkg::vaddr_t va);
        mmu_pkg::vaddr_t r;
        r = va;
        for (int b = 0; b < 12; b++) begin
            lfsr = lfsr_step(lfsr);
            r[b] = lfsr[0];
        end
        return r;
    endfunction

    function automatic mmu_pkg::tlb_page_t make_page(input logic [31:0] ppn, input logic [31:0] plv,
                                                     input logic [31:0] mat, input logic [31:0] d,
                                                     input logic [31:0] v);
        return {ppn[19:0], plv[1:0], mat[1:0], d[0], v[0]};
    endfunction

    function automatic logic window_ok(input mmu_pkg::dmw_cfg_t w, input mmu_pkg::vaddr_t va);
        logic plv_en;
        plv_en = (csr.crmd_plv == mmu_pkg::PLV_KERNEL && w.plv0)
              || (csr.crmd_plv == mmu_pkg::PLV_USER && w.plv3);
        return plv_en && (w.vseg == va[31:29]);
    endfunction

    function automatic mmu_pkg::tlb_hit_t model_search(input mmu_pkg::vaddr_t va);
        mmu_pkg::tlb_hit_t h;
        logic big;
        logic same_va;
        h = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            big = (model_tlb[i].ps == mmu_pkg::PS_4M);
            same_va = big ? (model_tlb[i].vppn[18:9] == va[31:22]) : (model_tlb[i].vppn == va[31:13]);
            if (model_tlb[i].e && (model_tlb[i].g || model_tlb[i].asid == csr.asid) && same_va) begin
                h.found = 1'b1;
                h.ps    = model_tlb[i].ps;
                h.page  = (big ? va[21] : va[12]) ? model_tlb[i].page1 : model_tlb[i].page0;
            end
        end
        return h;
    endfunction

    function automatic mmu_pkg::xlat_resp_t model_xlat(input mmu_pkg::vaddr_t va);
        mmu_pkg::xlat_resp_t r;
        mmu_pkg::tlb_hit_t   h;
        r = '0;
        r.valid = 1'b1;
        h = model_search(va);
        if (!csr.mapped) begin
            r.paddr = va;
            r.mat   = csr.datm;
        end else if (window_ok(csr.dmw0, va)) begin
            r.paddr = {csr.dmw0.pseg, va[28:0]};
            r.mat   = csr.dmw0.mat;
        end else if (window_ok(csr.dmw1, va)) begin
            r.paddr = {csr.dmw1.pseg, va[28:0]};
            r.mat   = csr.dmw1.mat;
        end else begin
            r.mat   = h.page.mat;
            r.paddr = (h.ps == mmu_pkg::PS_4M) ? {h.page.ppn[19:9], va[20:0]}
                                               : {h.page.ppn, va[11:0]};
        end
        return r;
    endfunction

    task automatic model_inv(input logic [4:0] op, input mmu_pkg::asid_t asid,
                             input mmu_pkg::vppn_t vppn);
        logic asid_eq;
        logic va_eq;
        logic kill;
        for (int i = 0; i < TLB_NUM; i++) begin
            asid_eq = (model_tlb[i].asid == asid);
            va_eq = (model_tlb[i].ps == mmu_pkg::PS_4M) ? (model_tlb[i].vppn[18:9] == vppn[18:9])
                                                        : (model_tlb[i].vppn == vppn);
            case (op)
                5'd0, 5'd1: kill = 1'b1;
                5'd2: kill = model_tlb[i].g;
                5'd3: kill = !model_tlb[i].g;
                5'd4: kill = !model_tlb[i].g && asid_eq;
                5'd5: kill = !model_tlb[i].g && asid_eq && va_eq;
                5'd6: kill = (model_tlb[i].g || asid_eq) && va_eq;
                default: kill = 1'b0;
            endcase
            if (kill) begin
                model_tlb[i].e = 1'b0;
            end
        end
    endtask

    task automatic expect_port(input string name, input mmu_pkg::vaddr_t va,
                               output mmu_pkg::xlat_resp_t r, output logic addr_chk);
        r = '0;
        r.valid = 1'b1;
        addr_chk = 1'b0;
        case (name)
            "compute": begin
                r = model_xlat(va);
                addr_chk = 1'b1;
            end
            "tlbr": r.exc = mmu_pkg::EXC_TLBR;
            "pif": r.exc = mmu_pkg::EXC_PIF;
            "pil": r.exc = mmu_pkg::EXC_PIL;
            "pis": r.exc = mmu_pkg::EXC_PIS;
            "ppi": r.exc = mmu_pkg::EXC_PPI;
            "pme": r.exc = mmu_pkg::EXC_PME;
            default: fail_now({"unknown expected result in case file: ", name});
        endcase
    endtask

    initial begin
        wait (cycle_limit > 0);
        wait (cycle_count >= cycle_limit);
        fail_now($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
    end

    initial begin
        int              fd;
        string           line;
        string           cmd;
        string           fexp;
        string           dexp;
        logic [31:0]     f [15];
        mmu_pkg::vaddr_t va;
        csr       = '0;
        tlb_we    = 1'b0;
        w_index   = '0;
        w_entry   = '0;
        inv       = '0;
        fetch_req = '0;
        data_req  = '0;
        exp_fetch = '0;
        exp_data  = '0;
        exp_fetch_addr = 1'b0;
        exp_data_addr  = 1'b0;
        foreach (model_tlb[i]) model_tlb[i] = '0;
        fd = $fopen("bench/mmu_cases.txt", "r");
        if (fd == 0) begin
            fail_now("could not open case file bench/mmu_cases.txt");
        end
        while ($fgets(line, fd) > 0) begin
            if ($sscanf(line, "%s", cmd) == 1 && cmd.getc(0) != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
        cycle_limit = 16 + 4 * lines.size() + 20;

        // no response may appear while reset is held
        @(negedge clk);
        while (!rst_n) begin
            check_port("fetch", fetch_resp, exp_fetch, 1'b0);
            check_port("data", data_resp, exp_data, 1'b0);
            @(negedge clk);
        end

        foreach (lines[k]) begin
            check_port("fetch", fetch_resp, exp_fetch, exp_fetch_addr);
            check_port("data", data_resp, exp_data, exp_data_addr);
            tlb_we        = 1'b0;
            inv.valid     = 1'b0;
            fetch_req.req = 1'b0;
            data_req.req  = 1'b0;
            exp_fetch     = '0;
            exp_data      = '0;
            void'($sscanf(lines[k], "%s", cmd));
            case (cmd)
                "csr": begin
                    need_fields($sscanf(lines[k], "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                        cmd, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                        f[8], f[9], f[10], f[11], f[12], f[13]), 15, lines[k]);
                    csr = {f[0][0], f[1][1:0], f[2][1:0], f[3][9:0],
                           f[4][0], f[5][0], f[6][2:0], f[7][2:0], f[8][1:0],
                           f[9][0], f[10][0], f[11][2:0], f[12][2:0], f[13][1:0]};
                end
                "write": begin
                    need_fields($sscanf(lines[k], "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                        cmd, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                        f[8], f[9], f[10], f[11], f[12], f[13], f[14]), 16, lines[k]);
                    w_index = f[0][3:0];
                    w_entry = {1'b1, f[1][18:0], f[2][5:0], f[3][9:0], f[4][0],
                               make_page(f[5], f[6], f[7], f[8], f[9]),
                               make_page(f[10], f[11], f[12], f[13], f[14])};
                    tlb_we = 1'b1;
                    model_tlb[f[0][3:0]] = w_entry;
                end
                "inv": begin
                    need_fields($sscanf(lines[k], "%s %h %h %h", cmd, f[0], f[1], f[2]), 4, lines[k]);
                    inv = {1'b1, f[0][4:0], f[1][9:0], f[2][18:0]};
                    model_inv(f[0][4:0], f[1][9:0], f[2][18:0]);
                end
                "fetch": begin
                    need_fields($sscanf(lines[k], "%s %h %s", cmd, f[0], fexp), 3, lines[k]);
                    va = random_offset(f[0]);
                    fetch_req = {1'b1, 1'b0, va};
                    expect_port(fexp, va, exp_fetch, exp_fetch_addr);
                end
                "data": begin
                    need_fields($sscanf(lines[k], "%s %h %h %s", cmd, f[0], f[1], dexp), 4, lines[k]);
                    va = random_offset(f[1]);
                    data_req = {1'b1, f[0][0], va};
                    expect_port(dexp, va, exp_data, exp_data_addr);
                end
                "both": begin
                    need_fields($sscanf(lines[k], "%s %h %h %s %s", cmd, f[0], f[1], fexp, dexp),
                                5, lines[k]);
                    va = random_offset(f[1]);
                    fetch_req = {1'b1, f[0][0], va};
                    data_req  = {1'b1, f[0][0], va};
                    expect_port(fexp, va, exp_fetch, exp_fetch_addr);
                    expect_port(dexp, va, exp_data, exp_data_addr);
                end
                default: fail_now({"unknown command in case file: ", lines[k]});
            endcase
            @(negedge clk);
        end

        // last response, then one idle cycle
        check_port("fetch", fetch_resp, exp_fetch, exp_fetch_addr);
        check_port("data", data_resp, exp_data, exp_data_addr);
        tlb_we        = 1'b0;
        inv.valid     = 1'b0;
        fetch_req.req = 1'b0;
        data_req.req  = 1'b0;
        exp_fetch     = '0;
        exp_data      = '0;
        @(negedge clk);
        check_port("fetch", fetch_resp, exp_fetch, 1'b0);
        check_port("data", data_resp, exp_data, 1'b0);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* mmu.f */
common/mmu_pkg.sv
tlb/tlb_array.sv
tlb/tlb_match.sv
hdl/addr_translate.sv
hdl/mmu_top.sv
bench/tb_clock.sv
bench/mmu_tb.sv

/* Bender.yml */
package:
  name: mmu

sources:
  - common/mmu_pkg.sv
  - tlb/tlb_array.sv
  - tlb/tlb_match.sv
  - hdl/addr_translate.sv
  - hdl/mmu_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/mmu_tb.sv

/* bench/mmu_cases.txt */
# hex fields, expected result is compute or an exception name
# csr mapped plv datm asid | dmw0 plv0 plv3 vseg pseg mat | dmw1 plv0 plv3 vseg pseg mat
# write idx vppn ps asid g | page0 ppn plv mat d v | page1 ppn plv mat d v
# inv op asid vppn | fetch vaddr exp | data wr vaddr exp | both wr vaddr fexp dexp
csr 1 0 0 005 1 0 4 0 1 1 1 4 2 2
both 0 00400000 tlbr tlbr
csr 0 0 2 005 1 0 4 0 1 1 1 4 2 2
both 1 12345000 compute compute
csr 1 0 0 005 1 0 4 0 1 1 1 4 2 2
both 0 80001000 compute compute
fetch a0000000 tlbr
write 0 00200 0c 005 0 11111 0 1 1 1 22222 3 2 0 1
write 1 00400 15 000 1 40000 0 1 1 1 60200 0 0 1 0
write 2 00300 0c 007 0 33333 0 1 1 1 33334 0 1 1 1
write 3 00800 0c 005 0 44444 0 1 0 1 55555 3 1 0 1
both 1 00400000 compute compute
both 1 00401000 compute pme
both 0 00800000 compute compute
both 1 00a00000 pif pis
data 0 00a00000 pil
both 0 00600000 tlbr tlbr
data 1 01000000 pme
csr 1 3 0 005 1 0 4 0 1 1 1 4 2 2
both 0 80002000 compute compute
both 1 01000000 ppi ppi
data 1 01001000 pme
fetch 00401000 compute
csr 1 0 0 005 1 0 4 0 1 1 1 4 2 2
inv 5 005 00200
fetch 00400000 tlbr
fetch 01000000 compute
inv 6 000 00400
fetch 00800000 tlbr
write 1 00400 15 000 1 40000 0 1 1 1 60200 0 0 1 0
fetch 00800000 compute
csr 1 0 0 007 1 0 4 0 1 1 1 4 2 2
data 0 00600000 compute
inv 4 007 00000
data 0 00600000 tlbr
fetch 00800000 compute
csr 1 0 0 005 1 0 4 0 1 1 1 4 2 2
inv 2 000 00000
fetch 00800000 tlbr
fetch 01000000 compute
inv 3 000 00000
fetch 01000000 tlbr
write 0 00200 0c 005 0 11111 0 1 1 1 22222 3 2 0 1
inv 7 000 00000
both 0 00400000 compute compute
inv 1 000 00000
fetch 00400000 tlbr
write 1 00400 15 000 1 40000 0 1 1 1 60200 0 0 1 0
inv 0 000 00000
fetch 00800000 tlbr
